// File: run.sh
#!/usr/bin/env bash
# Build the motor I/O core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_board \
	--Mdir obj_dir -o tb_board_sim > build.log 2>&1 \
	&& ./obj_dir/tb_board_sim > sim.log 2>&1 \
	|| { cat build.log; echo "TEST RESULT: FAIL" >> sim.log; }

cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: src/board_top.sv
// Top level of the four-motor I/O core
`timescale 1ns/1ps
`include "motor_cfg.svh"

module board_top (
	input  logic                  clk_100m,
	input  logic                  rst_n,
	input  logic                  fpga_rstn,
	input  logic                  sclk,
	input  logic                  mosi,
	input  logic                  cs_n,
	output logic                  miso,
	input  logic [3:0]            dip,
	input  motor_pkg::enc_in_t    enc [`NUM_MOTORS],
	output motor_pkg::motor_out_t motor_pins [`NUM_MOTORS]
);
	import motor_pkg::*;

	logic                   core_rst_n;
	reg_req_t               req;
	logic                   req_valid;
	logic [`DATA_W-1:0]     rdata;
	logic [`DATA_W-1:0]     motor_rdata [`NUM_MOTORS];
	logic [`NUM_MOTORS-1:0] motor_hit;

	reset_gen u_reset (.clk_100m(clk_100m), .rst_n(rst_n), .fpga_rstn(fpga_rstn),
		.core_rst_n(core_rst_n));

	spi_slave u_spi (.clk_100m(clk_100m), .core_rst_n(core_rst_n), .sclk(sclk),
		.mosi(mosi), .cs_n(cs_n), .miso(miso), .req(req), .req_valid(req_valid),
		.rdata(rdata));

	reg_map u_regs (.clk_100m(clk_100m), .core_rst_n(core_rst_n), .req(req), .dip(dip),
		.motor_rdata(motor_rdata), .motor_hit(motor_hit), .rdata(rdata));

	// One channel per motor, base address from the index
	for (genvar m = 0; m < `NUM_MOTORS; m++)
	begin : g_motor
		motor_channel #(.MOTOR_IDX(m)) u_motor (.clk_100m(clk_100m),
			.core_rst_n(core_rst_n), .req(req), .req_valid(req_valid), .enc(enc[m]),
			.pins(motor_pins[m]), .motor_rdata(motor_rdata[m]), .hit(motor_hit[m]));
	end

endmodule

// File: src/motor_cfg.svh
// Motor I/O core configuration: channel count, widths, timing and address map
`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Sizes
`define NUM_MOTORS    4
`define DATA_W        32
`define ADDR_W        15
`define OFS_W         8          // Offset bits inside one motor block

//////////////////////////////////////////////////////////////////////
// Timing
`define PWM_PERIOD    100        // Clock cycles per PWM period
`define PWM_W         16
`define RST_STRETCH   8          // Core reset hold after release
`define ENC_SYNC      2          // Input synchronizer stages

//////////////////////////////////////////////////////////////////////
// Register map
`define FPGA_VERSION  32'h0004_0100
`define ADDR_VERSION  15'h0000
`define ADDR_DIP      15'h0001
`define MOTOR_BASE(m) (15'h0100 * ((m) + 1))
`define UNMAPPED_DATA 32'hFFFF_FFFF

`endif

// File: src/motor_channel.sv
// One motor channel: register block, encoder counter, PWM and driver pins
`timescale 1ns/1ps
`include "motor_cfg.svh"

module motor_channel #(
	parameter int MOTOR_IDX = 0
) (
	input  logic                  clk_100m,
	input  logic                  core_rst_n,
	input  motor_pkg::reg_req_t   req,
	input  logic                  req_valid,
	input  motor_pkg::enc_in_t    enc,
	output motor_pkg::motor_out_t pins,
	output logic [`DATA_W-1:0]    motor_rdata,
	output logic                  hit
);
	import motor_pkg::*;

	localparam logic [`ADDR_W-1:0] BASE = `ADDR_W'(`MOTOR_BASE(MOTOR_IDX));

	logic               in_block, wr_en, preset_valid, pwm_out;
	logic [`OFS_W-1:0]  ofs;
	logic [`PWM_W-1:0]  pwm_cycle;
	motion_ctrl_t       motion;
	logic [`DATA_W-1:0] inc_cnt, inc_err;

	assign in_block     = (req.addr[`ADDR_W-1:`OFS_W] == BASE[`ADDR_W-1:`OFS_W]);
	assign ofs          = req.addr[`OFS_W-1:0];
	assign wr_en        = req_valid && req.write && in_block;
	assign preset_valid = wr_en && (ofs == OFS_INC_CNT);

	// Read side, gaps in the block are no hit
	always_comb
	begin
		hit         = in_block;
		motor_rdata = `UNMAPPED_DATA;
		case (ofs)
			OFS_INC_CNT:     motor_rdata = inc_cnt;
			OFS_INC_ERR:     motor_rdata = inc_err;
			OFS_PWM_CYCLE:   motor_rdata = `DATA_W'(pwm_cycle);
			OFS_MOTION_CTRL: motor_rdata = `DATA_W'(motion);
			default:         hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_100m)
	begin
		if (!core_rst_n)
		begin
			pwm_cycle <= '0;
			motion    <= '0;
		end
		else if (wr_en)
			case (ofs)
				OFS_PWM_CYCLE:   pwm_cycle <= req.wdata[`PWM_W-1:0];
				OFS_MOTION_CTRL: motion <= motion_ctrl_t'(req.wdata[$bits(motion_ctrl_t)-1:0]);
				default: ;                           // Error count is read only
			endcase
	end

	quad_decoder u_quad (.clk_100m(clk_100m), .core_rst_n(core_rst_n), .enc(enc),
		.preset_valid(preset_valid), .preset_val(req.wdata), .count(inc_cnt),
		.err_count(inc_err));

	pwm_gen u_pwm (.clk_100m(clk_100m), .core_rst_n(core_rst_n), .enable(motion.enable),
		.duty(pwm_cycle), .pwm(pwm_out));

	assign pins = '{pwm: pwm_out, brake: motion.brake, droff: ~motion.enable};

endmodule

// File: src/motor_pkg.sv
// Shared types of the motor I/O core: register access, pin bundles, offsets
`include "motor_cfg.svh"

package motor_pkg;

	// One register access from the SPI side
	typedef struct packed {
		logic               write;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic a;
		logic b;
	} enc_in_t;

	// Driver pins of one motor
	typedef struct packed {
		logic pwm;
		logic brake;
		logic droff;    // Active high driver off
	} motor_out_t;

	typedef enum logic [`OFS_W-1:0] {
		OFS_INC_CNT     = `OFS_W'd0,
		OFS_INC_ERR     = `OFS_W'd1,
		OFS_PWM_CYCLE   = `OFS_W'd2,
		OFS_MOTION_CTRL = `OFS_W'd3
	} reg_ofs_e;

	typedef struct packed {
		logic brake;    // bit 1
		logic enable;   // bit 0
	} motion_ctrl_t;

endpackage

// File: src/pwm_gen.sv
// Fixed-period PWM generator, duty clamped to the period
`timescale 1ns/1ps
`include "motor_cfg.svh"

module pwm_gen (
	input  logic             clk_100m,
	input  logic             core_rst_n,
	input  logic             enable,
	input  logic [`PWM_W-1:0] duty,
	output logic             pwm
);
	localparam int CNT_W  = $clog2(`PWM_PERIOD);
	localparam int DUTY_W = $clog2(`PWM_PERIOD + 1);

	logic [CNT_W-1:0]  period_cnt;
	logic [DUTY_W-1:0] duty_clamp, duty_q, duty_now;
	logic              period_start;

	assign period_start = (period_cnt == '0);
	assign duty_clamp   = (duty >= `PWM_W'(`PWM_PERIOD)) ? DUTY_W'(`PWM_PERIOD)
	                                                      : duty[DUTY_W-1:0];
	assign duty_now     = period_start ? duty_clamp : duty_q;   // New duty from cycle 0

	always_ff @(posedge clk_100m)
	begin
		if (!core_rst_n)
		begin
			period_cnt <= '0;
			duty_q     <= '0;
			pwm        <= 1'b0;
		end
		else
		begin
			period_cnt <= (period_cnt == CNT_W'(`PWM_PERIOD - 1)) ? '0 : period_cnt + 1'b1;
			if (period_start)
				duty_q <= duty_clamp;
			pwm <= enable && (DUTY_W'(period_cnt) < duty_now);
		end
	end

endmodule

// File: src/quad_decoder.sv
// x4 quadrature decoder with preset and illegal transition counter
`timescale 1ns/1ps
`include "motor_cfg.svh"

module quad_decoder (
	input  logic               clk_100m,
	input  logic               core_rst_n,
	input  motor_pkg::enc_in_t enc,
	input  logic               preset_valid,
	input  logic [`DATA_W-1:0] preset_val,
	output logic [`DATA_W-1:0] count,
	output logic [`DATA_W-1:0] err_count
);
	logic [`ENC_SYNC-1:0] a_sync, b_sync;
	logic [1:0]           prev, curr;   // {a, b}
	logic                 step_up, step_dn, illegal;

	assign curr    = {a_sync[`ENC_SYNC-1], b_sync[`ENC_SYNC-1]};
	assign illegal = &(prev ^ curr);    // Both phases moved at once

	// Gray order 00 01 11 10 counts up
	always_comb
	begin
		step_up = 1'b0;
		step_dn = 1'b0;
		case ({prev, curr})
			4'b0001, 4'b0111, 4'b1110, 4'b1000: step_up = 1'b1;
			4'b0010, 4'b1011, 4'b1101, 4'b0100: step_dn = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk_100m)
	begin
		if (!core_rst_n)
		begin
			a_sync    <= '0;
			b_sync    <= '0;
			prev      <= 2'b00;
			count     <= '0;
			err_count <= '0;
		end
		else
		begin
			a_sync <= {a_sync[`ENC_SYNC-2:0], enc.a};
			b_sync <= {b_sync[`ENC_SYNC-2:0], enc.b};
			prev   <= curr;
			if (preset_valid)
				count <= preset_val;        // Preset wins over a step
			else if (step_up)
				count <= count + 1'b1;
			else if (step_dn)
				count <= count - 1'b1;
			if (illegal)
				err_count <= err_count + 1'b1;
		end
	end

endmodule

// File: src/reg_map.sv
// Global registers and read multiplexer over the motor channels
`timescale 1ns/1ps
`include "motor_cfg.svh"

module reg_map (
	input  logic                clk_100m,
	input  logic                core_rst_n,
	input  motor_pkg::reg_req_t req,
	input  logic [3:0]          dip,
	input  logic [`DATA_W-1:0]  motor_rdata [`NUM_MOTORS],
	input  logic [`NUM_MOTORS-1:0] motor_hit,
	output logic [`DATA_W-1:0]  rdata
);
	logic [`ENC_SYNC-1:0][3:0] dip_sync;

	//////////////////////////////////////////////////////////////////////
	// DIP switch synchronizer
	always_ff @(posedge clk_100m)
	begin
		if (!core_rst_n)
			dip_sync <= '0;
		else
			dip_sync <= {dip_sync[`ENC_SYNC-2:0], dip};
	end

	//////////////////////////////////////////////////////////////////////
	// Read path
	always_comb
	begin
		rdata = `UNMAPPED_DATA;
		if (req.addr == `ADDR_VERSION)
			rdata = `FPGA_VERSION;
		else if (req.addr == `ADDR_DIP)
			rdata = `DATA_W'(dip_sync[`ENC_SYNC-1]);   // Zero extended
		else
		begin
			// Blocks do not overlap, at most one channel hits
			for (int m = 0; m < `NUM_MOTORS; m++)
			begin
				if (motor_hit[m])
					rdata = motor_rdata[m];
			end
		end
	end

endmodule

// File: src/reset_gen.sv
// Reset stretcher, merges board and FPGA reset into one core reset
`timescale 1ns/1ps
`include "motor_cfg.svh"

module reset_gen (
	input  logic clk_100m,
	input  logic rst_n,
	input  logic fpga_rstn,
	output logic core_rst_n
);
	localparam int CNT_W = $clog2(`RST_STRETCH + 1);

	logic [CNT_W-1:0] stretch_cnt;

	always_ff @(posedge clk_100m)
	begin
		if (!rst_n || !fpga_rstn)
		begin
			stretch_cnt <= CNT_W'(`RST_STRETCH);   // Reload while any input is low
			core_rst_n  <= 1'b0;
		end
		else
		begin
			if (stretch_cnt != '0)
				stretch_cnt <= stretch_cnt - 1'b1;
			core_rst_n <= (stretch_cnt <= CNT_W'(1));   // Release on last count
		end
	end

endmodule

// File: src/spi_slave.sv
// Mode-0 SPI slave, 48-bit frames turned into register reads and writes
`timescale 1ns/1ps
`include "motor_cfg.svh"

module spi_slave (
	input  logic                clk_100m,
	input  logic                core_rst_n,
	input  logic                sclk,
	input  logic                mosi,
	input  logic                cs_n,
	output logic                miso,
	output motor_pkg::reg_req_t req,
	output logic                req_valid,
	input  logic [`DATA_W-1:0]  rdata
);
	localparam int HDR_W   = 1 + `ADDR_W;        // Write flag plus address
	localparam int FRAME_W = HDR_W + `DATA_W;
	localparam int CNT_W   = $clog2(FRAME_W + 1);
	localparam logic [CNT_W-1:0] HDR_LAST   = CNT_W'(HDR_W - 1);
	localparam logic [CNT_W-1:0] HDR_DONE   = CNT_W'(HDR_W);
	localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(FRAME_W - 1);
	localparam logic [CNT_W-1:0] FRAME_END  = CNT_W'(FRAME_W);

	logic [`ENC_SYNC-1:0] sclk_sync, mosi_sync, cs_sync;
	logic                 sclk_s, mosi_s, cs_s, sclk_d;
	logic                 sclk_rise, sclk_fall;
	logic [CNT_W-1:0]     bit_cnt;
	logic [FRAME_W-2:0]   shift_in;              // Last bit comes straight from mosi_s
	logic [`DATA_W-1:0]   shift_out;

	assign sclk_s    = sclk_sync[`ENC_SYNC-1];
	assign mosi_s    = mosi_sync[`ENC_SYNC-1];
	assign cs_s      = cs_sync[`ENC_SYNC-1];
	assign sclk_rise = sclk_s & ~sclk_d;
	assign sclk_fall = ~sclk_s & sclk_d;
	assign miso      = shift_out[`DATA_W-1];

	//////////////////////////////////////////////////////////////////////
	// Control: synchronizers, bit counter, strobes and read shifter
	always_ff @(posedge clk_100m)
	begin
		if (!core_rst_n)
		begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			cs_sync   <= '1;
			sclk_d    <= 1'b0;
			bit_cnt   <= '0;
			req_valid <= 1'b0;
			shift_out <= '0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[`ENC_SYNC-2:0], sclk};
			mosi_sync <= {mosi_sync[`ENC_SYNC-2:0], mosi};
			cs_sync   <= {cs_sync[`ENC_SYNC-2:0], cs_n};
			sclk_d    <= sclk_s;
			req_valid <= 1'b0;

			if (cs_s)
				bit_cnt <= '0;                       // Deselect aborts the frame
			else if (sclk_rise && bit_cnt != FRAME_END)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == HDR_LAST)
					req_valid <= 1'b1;               // Read request after the header
				if (bit_cnt == FRAME_LAST)
					req_valid <= shift_in[FRAME_W-2]; // Write only if flagged
			end

			if (cs_s)
				shift_out <= '0;
			else if (req_valid && !req.write)
				shift_out <= rdata;                  // Answer is combinational
			else if (sclk_fall && bit_cnt > HDR_DONE)
				shift_out <= {shift_out[`DATA_W-2:0], 1'b0};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Payload: incoming bits and request fields
	always_ff @(posedge clk_100m)
	begin
		if (sclk_rise && !cs_s)
		begin
			shift_in <= {shift_in[FRAME_W-3:0], mosi_s};
			if (bit_cnt == HDR_LAST)
			begin
				req.write <= 1'b0;
				req.addr  <= {shift_in[HDR_W-3:0], mosi_s};
			end
			if (bit_cnt == FRAME_LAST)
			begin
				req.write <= shift_in[FRAME_W-2];
				req.wdata <= {shift_in[`DATA_W-2:0], mosi_s};
			end
		end
	end

endmodule

// File: tb.f
+incdir+src
src/motor_pkg.sv
src/reset_gen.sv
src/spi_slave.sv
src/quad_decoder.sv
src/pwm_gen.sv
src/motor_channel.sv
src/reg_map.sv
src/board_top.sv
tests/tb_board.sv

// File: tests/tb_board.sv
// Directed testbench for the four-motor I/O core over SPI, encoder and PWM pins
`timescale 1ns/1ps
`include "motor_cfg.svh"

module tb_board;
	import motor_pkg::*;

	localparam int SCLK_HALF = 5;              // 100 ns sclk period
	localparam int FRAME_W   = 1 + `ADDR_W + `DATA_W;
	localparam int ENC_MOTOR = 2;

	logic       clk_100m;
	logic       rst_n, fpga_rstn;
	logic       sclk, mosi, cs_n, miso;
	logic [3:0] dip;
	enc_in_t    enc [`NUM_MOTORS];
	motor_out_t motor_pins [`NUM_MOTORS];

	int                 errors;
	int                 tests;
	int                 failed;
	int                 enc_pos;               // Gray position of the driven encoder
	logic [`DATA_W-1:0] enc_preset;

	board_top uut (.clk_100m(clk_100m), .rst_n(rst_n), .fpga_rstn(fpga_rstn), .sclk(sclk),
		.mosi(mosi), .cs_n(cs_n), .miso(miso), .dip(dip), .enc(enc), .motor_pins(motor_pins));

	initial
	begin
		clk_100m = 1'b0;
		forever #5 clk_100m = ~clk_100m;
	end

	initial
	begin
		#2_000_000;
		$display("Simulation time limit reached before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk_100m);
	endtask

	function automatic logic [`ADDR_W-1:0] motor_addr(input int m, input logic [`OFS_W-1:0] ofs);
		return `ADDR_W'(`MOTOR_BASE(m) + ofs);
	endfunction

	// {a, b} along 00 01 11 10 is the forward direction
	function automatic enc_in_t gray_code(input int pos);
		case (((pos % 4) + 4) % 4)
			0:       return '{a: 1'b0, b: 1'b0};
			1:       return '{a: 1'b0, b: 1'b1};
			2:       return '{a: 1'b1, b: 1'b1};
			default: return '{a: 1'b1, b: 1'b0};
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Mode 0 frame sent MSB first with miso sampled just before each rising sclk
	task automatic spi_xfer(input logic wr, input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata);
		logic [FRAME_W-1:0] frame;
		frame = {wr, addr, wdata};
		rdata = '0;
		cs_n  = 1'b0;
		wait_cycles(SCLK_HALF);
		for (int i = FRAME_W - 1; i >= 0; i--)
		begin
			mosi = frame[i];
			wait_cycles(SCLK_HALF);
			if (i < `DATA_W)
				rdata[i] = miso;
			sclk = 1'b1;
			wait_cycles(SCLK_HALF);
			sclk = 1'b0;
		end
		wait_cycles(SCLK_HALF);
		cs_n = 1'b1;
		wait_cycles(2 * SCLK_HALF);   // Write settles well inside this gap
	endtask

	task automatic reg_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		logic [`DATA_W-1:0] ignored;
		spi_xfer(1'b1, addr, data, ignored);
	endtask

	task automatic expect_read(input string what, input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] exp);
		logic [`DATA_W-1:0] got;
		spi_xfer(1'b0, addr, '0, got);
		check(what, got, exp);
	endtask

	task automatic wait_pins(input int m, input logic brake, input logic droff);
		int n;
		n = 0;
		while ((motor_pins[m].brake !== brake || motor_pins[m].droff !== droff) && n < 10)
		begin
			@(negedge clk_100m);
			n++;
		end
		if (motor_pins[m].brake !== brake || motor_pins[m].droff !== droff)
		begin
			$display("Timeout at %0d ns: motor %0d pins never showed brake %b droff %b",
				$time, m, brake, droff);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
			$display("%s: passed", name);
		else
		begin
			failed++;
			$display("%s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	task automatic test_reset();
		int err_start;
		err_start = errors;
		check("miso idle", 32'(miso), 32'd0);
		for (int m = 0; m < `NUM_MOTORS; m++)
		begin
			check($sformatf("motor %0d pwm", m), 32'(motor_pins[m].pwm), 32'd0);
			check($sformatf("motor %0d brake", m), 32'(motor_pins[m].brake), 32'd0);
			check($sformatf("motor %0d droff", m), 32'(motor_pins[m].droff), 32'd1);
			expect_read("count", motor_addr(m, OFS_INC_CNT), '0);
			expect_read("error count", motor_addr(m, OFS_INC_ERR), '0);
			expect_read("pwm cycle", motor_addr(m, OFS_PWM_CYCLE), '0);
			expect_read("motion ctrl", motor_addr(m, OFS_MOTION_CTRL), '0);
		end
		expect_read("version", `ADDR_VERSION, `FPGA_VERSION);
		expect_read("dip", `ADDR_DIP, {28'd0, dip});
		end_test("reset and global registers", err_start);
	endtask

	task automatic test_unmapped();
		int                 err_start;
		logic [`ADDR_W-1:0] addrs [6];
		err_start = errors;
		addrs = '{15'h0002, 15'h00FF, motor_addr(`NUM_MOTORS, 8'd0), 15'h7FFF,
			motor_addr(0, 8'd4), motor_addr(3, 8'hFF)};
		foreach (addrs[i])
			expect_read($sformatf("address %h", addrs[i]), addrs[i], `UNMAPPED_DATA);
		end_test("unmapped addresses", err_start);
	endtask

	task automatic test_registers();
		int                 err_start;
		logic [`DATA_W-1:0] cycle_val, ctrl_val;
		err_start = errors;
		for (int m = 0; m < `NUM_MOTORS; m++)
		begin
			cycle_val = $urandom;
			ctrl_val  = $urandom;
			reg_write(motor_addr(m, OFS_PWM_CYCLE), cycle_val);
			reg_write(motor_addr(m, OFS_MOTION_CTRL), ctrl_val);
			expect_read("pwm cycle", motor_addr(m, OFS_PWM_CYCLE), cycle_val & 32'h0000_FFFF);
			expect_read("motion ctrl", motor_addr(m, OFS_MOTION_CTRL), ctrl_val & 32'h3);
			wait_pins(m, ctrl_val[1], ~ctrl_val[0]);   // Brake is bit 1 and enable bit 0
		end
		end_test("motor registers and pins", err_start);
	endtask

	task automatic test_encoder();
		int err_start, fwd, bwd;
		err_start = errors;
		fwd = 0;
		bwd = 0;
		for (int i = 0; i < 24; i++)
		begin
			if ($urandom_range(3, 0) != 0)
			begin
				enc_pos++;
				fwd++;
			end
			else
			begin
				enc_pos--;
				bwd++;
			end
			enc[ENC_MOTOR] = gray_code(enc_pos);
			wait_cycles(8);
		end
		for (int m = 0; m < `NUM_MOTORS; m++)
			expect_read($sformatf("motor %0d count", m), motor_addr(m, OFS_INC_CNT),
				(m == ENC_MOTOR) ? `DATA_W'(fwd - bwd) : '0);
		enc_preset = $urandom;
		reg_write(motor_addr(ENC_MOTOR, OFS_INC_CNT), enc_preset);
		expect_read("preset count", motor_addr(ENC_MOTOR, OFS_INC_CNT), enc_preset);
		end_test("encoder count and preset", err_start);
	endtask

	task automatic test_illegal();
		int err_start;
		err_start = errors;
		for (int k = 0; k < 3; k++)
		begin
			enc_pos += 2;                           // Both phases flip together
			enc[ENC_MOTOR] = gray_code(enc_pos);
			wait_cycles(8);
			expect_read("error count", motor_addr(ENC_MOTOR, OFS_INC_ERR), `DATA_W'(k + 1));
		end
		expect_read("count after errors", motor_addr(ENC_MOTOR, OFS_INC_CNT), enc_preset);
		end_test("illegal transitions", err_start);
	endtask

	task automatic test_pwm(input string name, input int m, input logic [`PWM_W-1:0] duty,
		input logic enable);
		int err_start, high, expected;
		err_start = errors;
		high = 0;
		reg_write(motor_addr(m, OFS_PWM_CYCLE), `DATA_W'(duty));
		reg_write(motor_addr(m, OFS_MOTION_CTRL), {31'd0, enable});
		wait_cycles(2 * `PWM_PERIOD);
		for (int i = 0; i < `PWM_PERIOD; i++)
		begin
			if (motor_pins[m].pwm)
				high++;
			@(negedge clk_100m);
		end
		expected = enable ? ((duty < `PWM_PERIOD) ? int'(duty) : `PWM_PERIOD) : 0;
		check($sformatf("motor %0d pwm high cycles", m), 32'(high), 32'(expected));
		end_test(name, err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence
	initial
	begin
		void'($urandom(63));
		errors    = 0;
		tests     = 0;
		failed    = 0;
		enc_pos   = 0;
		sclk      = 1'b0;
		mosi      = 1'b0;
		cs_n      = 1'b1;
		rst_n     = 1'b0;
		fpga_rstn = 1'b0;
		dip       = 4'($urandom);
		for (int m = 0; m < `NUM_MOTORS; m++)
			enc[m] = '{a: 1'b0, b: 1'b0};
		wait_cycles(5);
		rst_n     = 1'b1;
		fpga_rstn = 1'b1;
		wait_cycles(`RST_STRETCH + 2);            // Core reset release

		test_reset();
		test_unmapped();
		test_registers();
		test_encoder();
		test_illegal();
		test_pwm("pwm random duty", 0, 16'($urandom_range(99, 1)), 1'b1);
		test_pwm("pwm duty above period", 3, 16'd250, 1'b1);
		test_pwm("pwm disabled", 1, 16'($urandom_range(99, 1)), 1'b0);

		$display("Tests run %0d, failed %0d, check errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
